// ==== dcache.f ====
+incdir+.
dcache_tlb_pkg.sv
dcache_mem_pkg.sv
dcache_if.sv
dtlb.sv
access_split.sv
cache_bank.sv
output_align.sv
dcache.sv
tb_clock_gen.sv
tb_dcache.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the dcache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f dcache.f --top-module tb_dcache -o sim_dcache
if [ $? -ne 0 ]; then
   echo "Compilation failed"
   exit 1
fi

sim_out=$(./obj_dir/sim_dcache)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if echo "$sim_out" | grep -qx "Verification passed"; then
   exit 0
fi
exit 1

// ==== tb_dcache.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "dcache_cfg.svh"

module tb_dcache
   import dcache_tlb_pkg::*;
   import dcache_mem_pkg::*;
();

   localparam int   MAX_WAIT = 10;
   localparam vpn_t PG_RW    = 20'h00010;
   localparam vpn_t PG_RO    = 20'h00011;
   localparam vpn_t PG_NP    = 20'h00012;
   localparam vpn_t PG_RW2   = 20'h00013;
   localparam vpn_t PG_NONE  = 20'h00077;

   logic          clk;
   logic          arst_n;
   logic          rd_valid;
   vaddr_t        rd_vaddr;
   opsize_t       rd_size;
   logic          wb_valid;
   vaddr_t        wb_vaddr;
   line_t         wb_line;
   tlb_vpn_vec_t  tlb_vp;
   tlb_ppn_vec_t  tlb_pf;
   tlb_flag_vec_t tlb_v;
   tlb_flag_vec_t tlb_p;
   tlb_flag_vec_t tlb_rw;
   logic          rd_done;
   logic          rd_hit;
   logic          rd_tlb_miss;
   logic          rd_prot;
   word_t         rd_data;
   logic          wb_fault;

   // Page table mirrored into TLB entries 0..3
   vpn_t  pt_vpn [4] = '{PG_RW, PG_RO, PG_NP, PG_RW2};
   ppn_t  pt_ppn [4] = '{3'd1, 3'd2, 3'd3, 3'd5};
   logic  pt_p   [4] = '{1'b1, 1'b1, 1'b0, 1'b1};
   logic  pt_rw  [4] = '{1'b1, 1'b0, 1'b0, 1'b1};

   // Expected cache contents per bank and set
   line_t m_line  [2][8];
   tag_t  m_tag   [2][8];
   logic  m_valid [2][8];

   int checks;
   int errors;

   tb_clock_gen clock_gen_inst (.clk_o(clk), .arst_n_o(arst_n));

   dcache dcache_inst (
      .clk(clk), .arst_n_i(arst_n),
      .rd_valid_i(rd_valid), .rd_vaddr_i(rd_vaddr), .rd_size_i(rd_size),
      .wb_valid_i(wb_valid), .wb_vaddr_i(wb_vaddr), .wb_line_i(wb_line),
      .tlb_vp_i(tlb_vp), .tlb_pf_i(tlb_pf), .tlb_v_i(tlb_v), .tlb_p_i(tlb_p),
      .tlb_rw_i(tlb_rw),
      .rd_valid_o(rd_done), .rd_hit_o(rd_hit), .rd_tlb_miss_o(rd_tlb_miss),
      .rd_prot_o(rd_prot), .rd_data_o(rd_data), .wb_fault_o(wb_fault)
   );

   task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
      checks++;
      if (got !== exp) begin
         $display("Mismatch at %0t: %s, got %h, expected %h", $time, what, got, exp);
         errors++;
      end
   endtask

   function automatic vaddr_t va_of(input vpn_t pg, input logic [11:0] ofs);
      return {pg, ofs};
   endfunction

   function automatic line_t rand_line();
      return {$urandom, $urandom, $urandom, $urandom};
   endfunction

   // Returns 1 when a present entry maps the page
   function automatic logic translate_va(input vaddr_t va, output paddr_t pa,
                                         output logic rw);
      translate_va = 1'b0;
      pa = '0;
      rw = 1'b0;
      for (int i = 0; i < 4; i++) begin
         if (pt_vpn[i] == va[31:12] && pt_p[i]) begin
            translate_va = 1'b1;
            pa = {pt_ppn[i], va[11:0]};
            rw = pt_rw[i];
         end
      end
   endfunction

   function automatic void predict_read(input paddr_t pa, input opsize_t size,
                                        output logic hit, output word_t data);
      int     nb;
      paddr_t b;
      nb = 1 << size;
      hit = 1'b1;
      data = '0;
      for (int k = 0; k < 8; k++) begin
         if (k < nb) begin
            b = pa + paddr_t'(k);
            if (!(m_valid[b[4]][b[7:5]] && m_tag[b[4]][b[7:5]] == b[14:8])) begin
               hit = 1'b0;
            end
            data[k*8 +: 8] = m_line[b[4]][b[7:5]][b[3:0]*8 +: 8];
         end
      end
      if (!hit) begin
         data = '0;
      end
   endfunction

   task automatic do_read(input vaddr_t va, input opsize_t size, output logic hit,
                          output logic miss, output word_t data, output int lat);
      logic seen;
      seen = 1'b0;
      lat = 0;
      hit = 1'b0;
      miss = 1'b0;
      data = '0;
      @(posedge clk);
      rd_valid <= 1'b1;
      rd_vaddr <= va;
      rd_size  <= size;
      while (!seen && lat < MAX_WAIT) begin
         @(posedge clk);
         rd_valid <= 1'b0;
         lat++;
         @(negedge clk);
         if (rd_done) begin
            seen = 1'b1;
            hit  = rd_hit;
            miss = rd_tlb_miss;
            data = rd_data;
            check($sformatf("read %h prot", va), 64'(rd_prot), 64'd0);
         end
      end
      if (!seen) begin
         $display("Timeout: no read result for address %h after %0d cycles", va, lat);
         errors++;
      end
   endtask

   task automatic read_and_compare(input vaddr_t va, input opsize_t size);
      paddr_t pa;
      logic   mapped;
      logic   rw;
      logic   exp_hit;
      word_t  exp_data;
      logic   hit;
      logic   miss;
      word_t  data;
      int     lat;
      mapped = translate_va(va, pa, rw);
      exp_hit = 1'b0;
      exp_data = '0;
      if (mapped) begin
         predict_read(pa, size, exp_hit, exp_data);
      end
      do_read(va, size, hit, miss, data, lat);
      check($sformatf("read %h latency", va), 64'(lat), 64'd2);
      check($sformatf("read %h tlb miss", va), 64'(miss), 64'(!mapped));
      check($sformatf("read %h hit", va), 64'(hit), 64'(exp_hit));
      check($sformatf("read %h size %0d data", va, size), data, exp_data);
   endtask

   task automatic write_back(input vaddr_t va, input line_t line);
      paddr_t pa;
      logic   mapped;
      logic   rw;
      logic   exp_fault;
      int     fault_cycle;
      mapped = translate_va(va, pa, rw);
      exp_fault = !(mapped && rw);
      fault_cycle = 0;
      @(posedge clk);
      wb_valid <= 1'b1;
      wb_vaddr <= va;
      wb_line  <= line;
      for (int c = 1; c <= 3; c++) begin
         @(posedge clk);
         wb_valid <= 1'b0;
         @(negedge clk);
         if (wb_fault && fault_cycle == 0) begin
            fault_cycle = c;
         end
      end
      check($sformatf("write-back %h fault cycle", va), 64'(fault_cycle),
            exp_fault ? 64'd1 : 64'd0);
      if (!exp_fault) begin
         m_valid[pa[4]][pa[7:5]] = 1'b1;
         m_tag[pa[4]][pa[7:5]]   = pa[14:8];
         m_line[pa[4]][pa[7:5]]  = line;
      end
   endtask

   task automatic end_test(input string name, input int err_start);
      $display("%s: done, %0d errors", name, errors - err_start);
   endtask

   task automatic read_after_reset();
      int e;
      e = errors;
      read_and_compare(va_of(PG_RW, 12'h040), 2'd3);
      end_test("after_reset", e);
   endtask

   task automatic aligned_reads();
      int e;
      e = errors;
      write_back(va_of(PG_RW, 12'h040), rand_line());
      write_back(va_of(PG_RW, 12'h050), rand_line());
      for (int s = 0; s < 4; s++) begin
         for (int o = 0; o < 4; o++) begin
            read_and_compare(va_of(PG_RW, 12'h040 + 12'(o * 8 + ((s < 3) ? (1 << s) : 0))),
                             opsize_t'(s));
         end
      end
      end_test("aligned_reads", e);
   endtask

   task automatic line_crossing_reads();
      int e;
      e = errors;
      // Even line first and odd line second
      write_back(va_of(PG_RW, 12'h100), rand_line());
      read_and_compare(va_of(PG_RW, 12'h10e), 2'd3);
      write_back(va_of(PG_RW, 12'h110), rand_line());
      read_and_compare(va_of(PG_RW, 12'h10e), 2'd3);
      // Odd line first and the next even set second
      write_back(va_of(PG_RW, 12'h140), rand_line());
      read_and_compare(va_of(PG_RW, 12'h13e), 2'd3);
      write_back(va_of(PG_RW, 12'h130), rand_line());
      read_and_compare(va_of(PG_RW, 12'h13e), 2'd3);
      // Set 7 wraps to set 0 of the next tag
      write_back(va_of(PG_RW, 12'h1f0), rand_line());
      write_back(va_of(PG_RW, 12'h200), rand_line());
      read_and_compare(va_of(PG_RW, 12'h1fe), 2'd3);
      end_test("line_crossing", e);
   endtask

   task automatic fault_handling();
      int e;
      e = errors;
      read_and_compare(va_of(PG_NONE, 12'h040), 2'd2);
      read_and_compare(va_of(PG_NP, 12'h040), 2'd2);
      write_back(va_of(PG_RO, 12'h080), rand_line());
      read_and_compare(va_of(PG_RO, 12'h080), 2'd3);
      end_test("faults", e);
   endtask

   task automatic back_to_back_reads();
      vaddr_t va [8];
      word_t  exp_data [8];
      logic   exp_hit [8];
      paddr_t pa;
      logic   rw;
      int     got;
      int     cyc;
      int     e;
      e = errors;
      // Fresh even line so every read returns distinct data
      write_back(va_of(PG_RW, 12'h040), rand_line());
      for (int k = 0; k < 8; k++) begin
         va[k] = va_of(PG_RW, 12'h040 + 12'(k * 4));
         void'(translate_va(va[k], pa, rw));
         predict_read(pa, 2'd2, exp_hit[k], exp_data[k]);
      end
      got = 0;
      cyc = 0;
      while (got < 8 && cyc < 8 + MAX_WAIT) begin
         @(posedge clk);
         if (cyc < 8) begin
            rd_valid <= 1'b1;
            rd_vaddr <= va[cyc];
            rd_size  <= 2'd2;
         end else begin
            rd_valid <= 1'b0;
         end
         @(negedge clk);
         if (rd_done) begin
            check($sformatf("pipelined read %0d cycle", got), 64'(cyc), 64'(got + 2));
            check($sformatf("pipelined read %0d hit", got), 64'(rd_hit), 64'(exp_hit[got]));
            check($sformatf("pipelined read %0d data", got), rd_data, exp_data[got]);
            got++;
         end
         cyc++;
      end
      if (got < 8) begin
         $display("Timeout: only %0d of 8 pipelined reads returned", got);
         errors++;
      end
      end_test("back_to_back", e);
   endtask

   task automatic same_index_evict();
      int e;
      e = errors;
      write_back(va_of(PG_RW2, 12'h260), rand_line());
      write_back(va_of(PG_RW2, 12'h360), rand_line());
      read_and_compare(va_of(PG_RW2, 12'h260), 2'd3);
      read_and_compare(va_of(PG_RW2, 12'h360), 2'd3);
      end_test("same_index_evict", e);
   endtask

   initial begin
      int n;
      void'($urandom(25696));
      checks = 0;
      errors = 0;
      for (int b = 0; b < 2; b++) begin
         for (int i = 0; i < 8; i++) begin
            m_valid[b][i] = 1'b0;
            m_tag[b][i]   = '0;
            m_line[b][i]  = '0;
         end
      end
      rd_valid <= 1'b0;
      rd_vaddr <= '0;
      rd_size  <= '0;
      wb_valid <= 1'b0;
      wb_vaddr <= '0;
      wb_line  <= '0;
      // Entries 4..7 stay invalid
      for (int i = 0; i < 8; i++) begin
         tlb_vp[i*20 +: 20] <= (i < 4) ? pt_vpn[i] : 20'hf0000 + 20'(i);
         tlb_pf[i*20 +: 20] <= (i < 4) ? {17'd0, pt_ppn[i]} : 20'd0;
         tlb_v[i]  <= (i < 4);
         tlb_p[i]  <= (i < 4) && pt_p[i];
         tlb_rw[i] <= (i < 4) && pt_rw[i];
      end
      n = 0;
      while (arst_n !== 1'b1 && n < 20) begin
         @(posedge clk);
         n++;
      end
      if (arst_n !== 1'b1) begin
         $display("Reset never released");
         errors++;
      end
      read_after_reset();
      aligned_reads();
      line_crossing_reads();
      fault_handling();
      back_to_back_reads();
      same_index_evict();
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
   output logic clk_o,
   output logic arst_n_o
);

   localparam int HALF_PERIOD = 10;

   initial begin
      clk_o = 1'b0;
      forever #HALF_PERIOD clk_o = ~clk_o;
   end

   // Held for four rising edges, released away from the edge
   initial begin
      arst_n_o = 1'b0;
      repeat (4) @(posedge clk_o);
      @(negedge clk_o);
      arst_n_o = 1'b1;
   end

endmodule

`default_nettype wire

// ==== dcache.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "dcache_cfg.svh"

module dcache
   import dcache_tlb_pkg::*;
   import dcache_mem_pkg::*;
(
   input  wire logic          clk,
   input  wire logic          arst_n_i,
   input  wire logic          rd_valid_i,
   input  wire vaddr_t        rd_vaddr_i,
   input  wire opsize_t       rd_size_i,
   input  wire logic          wb_valid_i,
   input  wire vaddr_t        wb_vaddr_i,
   input  wire line_t         wb_line_i,
   input  wire tlb_vpn_vec_t  tlb_vp_i,
   input  wire tlb_ppn_vec_t  tlb_pf_i,
   input  wire tlb_flag_vec_t tlb_v_i,
   input  wire tlb_flag_vec_t tlb_p_i,
   input  wire tlb_flag_vec_t tlb_rw_i,
   output logic               rd_valid_o,
   output logic               rd_hit_o,
   output logic               rd_tlb_miss_o,
   output logic               rd_prot_o,
   output word_t              rd_data_o,
   output logic               wb_fault_o
);

   paddr_t rd_paddr;
   paddr_t wb_paddr;
   logic   rd_hit;
   logic   rd_miss;
   logic   wb_hit;
   logic   wb_prot;
   logic   bank_e_hit;
   logic   bank_o_hit;
   line_t  bank_e_line;
   line_t  bank_o_line;

   bank_req_if bank_e_if ();
   bank_req_if bank_o_if ();
   rd_meta_if  meta_if ();

   dtlb rd_tlb (
      .vaddr_i(rd_vaddr_i), .is_write_i(1'b0),
      .vp_i(tlb_vp_i), .pf_i(tlb_pf_i), .v_i(tlb_v_i), .p_i(tlb_p_i), .rw_i(tlb_rw_i),
      .paddr_o(rd_paddr), .hit_o(rd_hit), .miss_o(rd_miss), .prot_o()
   );

   dtlb wb_tlb (
      .vaddr_i(wb_vaddr_i), .is_write_i(1'b1),
      .vp_i(tlb_vp_i), .pf_i(tlb_pf_i), .v_i(tlb_v_i), .p_i(tlb_p_i), .rw_i(tlb_rw_i),
      .paddr_o(wb_paddr), .hit_o(wb_hit), .miss_o(), .prot_o(wb_prot)
   );

   access_split access_split_inst (
      .clk(clk), .arst_n_i(arst_n_i),
      .rd_valid_i(rd_valid_i), .rd_size_i(rd_size_i), .rd_paddr_i(rd_paddr),
      .rd_hit_i(rd_hit), .rd_miss_i(rd_miss),
      .wb_valid_i(wb_valid_i), .wb_paddr_i(wb_paddr), .wb_line_i(wb_line_i),
      .wb_hit_i(wb_hit), .wb_prot_i(wb_prot), .wb_fault_o(wb_fault_o),
      .bank_e(bank_e_if.split), .bank_o(bank_o_if.split), .meta(meta_if.split)
   );

   cache_bank bank_e (
      .clk(clk), .arst_n_i(arst_n_i), .req(bank_e_if.bank),
      .hit_o(bank_e_hit), .line_o(bank_e_line)
   );

   cache_bank bank_o (
      .clk(clk), .arst_n_i(arst_n_i), .req(bank_o_if.bank),
      .hit_o(bank_o_hit), .line_o(bank_o_line)
   );

   output_align output_align_inst (
      .clk(clk), .arst_n_i(arst_n_i),
      .hit_e_i(bank_e_hit), .line_e_i(bank_e_line),
      .hit_o_i(bank_o_hit), .line_o_i(bank_o_line),
      .meta(meta_if.align),
      .rd_valid_o(rd_valid_o), .rd_hit_o(rd_hit_o), .rd_tlb_miss_o(rd_tlb_miss_o),
      .rd_prot_o(rd_prot_o), .rd_data_o(rd_data_o)
   );

endmodule

`default_nettype wire

// ==== output_align.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "dcache_cfg.svh"

module output_align
   import dcache_mem_pkg::*;
(
   input  wire logic  clk,
   input  wire logic  arst_n_i,
   input  wire logic  hit_e_i,
   input  wire line_t line_e_i,
   input  wire logic  hit_o_i,
   input  wire line_t line_o_i,
   rd_meta_if.align   meta,
   output logic       rd_valid_o,
   output logic       rd_hit_o,
   output logic       rd_tlb_miss_o,
   output logic       rd_prot_o,
   output word_t      rd_data_o
);

   logic                        valid_q;
   logic                        miss_q;
   logic                        prot_q;
   offset_t                     offset_q;
   opsize_t                     size_q;
   logic                        first_odd_q;
   logic                        two_lines_q;
   line_t                       lo_line;
   line_t                       hi_line;
   logic [2*`DC_LINE_BYTES*8-1:0] shifted;
   word_t                       byte_mask;
   logic                        line_hit;

   // Same stage as the bank read
   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         valid_q <= 1'b0;
         miss_q  <= 1'b0;
         prot_q  <= 1'b0;
      end else begin
         valid_q <= meta.valid;
         miss_q  <= meta.tlb_miss;
         prot_q  <= meta.prot_fault;
      end
   end

   always_ff @(posedge clk) begin
      offset_q    <= meta.offset;
      size_q      <= meta.size;
      first_odd_q <= meta.first_odd;
      two_lines_q <= meta.two_lines;
   end

   // Lower address line first
   assign lo_line  = first_odd_q ? line_o_i : line_e_i;
   assign hi_line  = first_odd_q ? line_e_i : line_o_i;
   assign shifted  = {hi_line, lo_line} >> {offset_q, 3'b000};
   assign line_hit = (first_odd_q ? hit_o_i : hit_e_i)
                  && (!two_lines_q || (first_odd_q ? hit_e_i : hit_o_i));

   always_comb begin
      for (int k = 0; k < `DC_WORD_BYTES; k++) begin
         byte_mask[k*8 +: 8] = (k < (1 << size_q)) ? 8'hff : 8'h00;
      end
   end

   assign rd_valid_o    = valid_q;
   assign rd_tlb_miss_o = valid_q && miss_q;
   assign rd_prot_o     = valid_q && prot_q;
   assign rd_hit_o      = valid_q && !miss_q && !prot_q && line_hit;
   assign rd_data_o     = rd_hit_o ? (shifted[`DC_WORD_BYTES*8-1:0] & byte_mask) : '0;

endmodule

`default_nettype wire

// ==== cache_bank.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "dcache_cfg.svh"

module cache_bank
   import dcache_mem_pkg::*;
(
   input  wire logic clk,
   input  wire logic arst_n_i,
   bank_req_if.bank  req,
   output logic      hit_o,
   output line_t     line_o
);

   line_t                        lines [`DC_SETS_PER_BANK];
   tag_t                         tags  [`DC_SETS_PER_BANK];
   logic [`DC_SETS_PER_BANK-1:0] valid;
   logic                         tag_match;

   assign tag_match = valid[req.rd_index] && (tags[req.rd_index] == req.rd_tag);

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         valid <= '0;
         hit_o <= 1'b0;
      end else begin
         if (req.wr_valid) begin
            valid[req.wr_index] <= 1'b1;
         end
         // Idle cycles report no hit
         hit_o <= req.rd_valid && tag_match;
      end
   end

   // Read sees the array before a write on the same edge
   always_ff @(posedge clk) begin
      if (req.wr_valid) begin
         lines[req.wr_index] <= req.wr_line;
         tags[req.wr_index]  <= req.wr_tag;
      end
      if (req.rd_valid) begin
         line_o <= lines[req.rd_index];
      end
   end

   a_wr_line_known : assert property (@(posedge clk) disable iff (!arst_n_i)
      req.wr_valid |-> !$isunknown(req.wr_line))
      else $error("cache_bank: write of unknown line data at index %0d", req.wr_index);

endmodule

`default_nettype wire

// ==== access_split.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "dcache_cfg.svh"

module access_split
   import dcache_mem_pkg::*;
(
   input  wire logic    clk,
   input  wire logic    arst_n_i,
   input  wire logic    rd_valid_i,
   input  wire opsize_t rd_size_i,
   input  wire paddr_t  rd_paddr_i,
   input  wire logic    rd_hit_i,
   input  wire logic    rd_miss_i,
   input  wire logic    wb_valid_i,
   input  wire paddr_t  wb_paddr_i,
   input  wire line_t   wb_line_i,
   input  wire logic    wb_hit_i,
   input  wire logic    wb_prot_i,
   output logic         wb_fault_o,
   bank_req_if.split    bank_e,
   bank_req_if.split    bank_o,
   rd_meta_if.split     meta
);

   localparam int LINE_ADDR_W = `DC_PADDR_W - OFFSET_W;

   logic                   rd_valid_q;
   logic                   rd_hit_q;
   logic                   rd_miss_q;
   opsize_t                rd_size_q;
   paddr_t                 rd_paddr_q;
   logic                   wb_valid_q;
   paddr_t                 wb_paddr_q;
   line_t                  wb_line_q;
   logic [LINE_ADDR_W-1:0] line_a;
   logic [LINE_ADDR_W-1:0] line_b;
   logic [LINE_ADDR_W-1:0] line_even;
   logic [LINE_ADDR_W-1:0] line_odd;
   logic [OFFSET_W:0]      nbytes;
   logic [OFFSET_W:0]      end_byte;
   logic                   first_odd;
   logic                   two_lines;
   logic                   rd_go;
   logic [`DC_PAGE_OFS_W:0] page_end;

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rd_valid_q <= 1'b0;
         rd_hit_q   <= 1'b0;
         rd_miss_q  <= 1'b0;
         wb_valid_q <= 1'b0;
         wb_fault_o <= 1'b0;
      end else begin
         rd_valid_q <= rd_valid_i;
         rd_hit_q   <= rd_valid_i && rd_hit_i;
         rd_miss_q  <= rd_valid_i && rd_miss_i;
         // Only clean write-backs reach a bank
         wb_valid_q <= wb_valid_i && wb_hit_i;
         wb_fault_o <= wb_valid_i && (wb_prot_i || !wb_hit_i);
      end
   end

   always_ff @(posedge clk) begin
      rd_size_q  <= rd_size_i;
      rd_paddr_q <= rd_paddr_i;
      wb_paddr_q <= wb_paddr_i;
      wb_line_q  <= wb_line_i;
   end

   // First line and the one after it
   assign line_a    = rd_paddr_q[`DC_PADDR_W-1:OFFSET_W];
   assign line_b    = line_a + 1'b1;
   assign first_odd = line_a[0];
   assign line_even = first_odd ? line_b : line_a;
   assign line_odd  = first_odd ? line_a : line_b;

   assign nbytes    = (OFFSET_W+1)'(1) << rd_size_q;
   assign end_byte  = {1'b0, rd_paddr_q[OFFSET_W-1:0]} + nbytes;
   assign two_lines = end_byte > `DC_LINE_BYTES;
   assign rd_go     = rd_valid_q && rd_hit_q;

   assign bank_e.rd_valid = rd_go && (!first_odd || two_lines);
   assign bank_e.rd_index = line_even[INDEX_W:1];
   assign bank_e.rd_tag   = line_even[LINE_ADDR_W-1:INDEX_W+1];
   assign bank_o.rd_valid = rd_go && (first_odd || two_lines);
   assign bank_o.rd_index = line_odd[INDEX_W:1];
   assign bank_o.rd_tag   = line_odd[LINE_ADDR_W-1:INDEX_W+1];

   // Full-line write-back goes to one bank only
   assign bank_e.wr_valid = wb_valid_q && !wb_paddr_q[OFFSET_W];
   assign bank_o.wr_valid = wb_valid_q && wb_paddr_q[OFFSET_W];
   assign bank_e.wr_index = wb_paddr_q[OFFSET_W+1 +: INDEX_W];
   assign bank_o.wr_index = wb_paddr_q[OFFSET_W+1 +: INDEX_W];
   assign bank_e.wr_tag   = wb_paddr_q[`DC_PADDR_W-1 -: TAG_W];
   assign bank_o.wr_tag   = wb_paddr_q[`DC_PADDR_W-1 -: TAG_W];
   assign bank_e.wr_line  = wb_line_q;
   assign bank_o.wr_line  = wb_line_q;

   assign meta.valid      = rd_valid_q;
   assign meta.offset     = rd_paddr_q[OFFSET_W-1:0];
   assign meta.size       = rd_size_q;
   assign meta.first_odd  = first_odd;
   assign meta.two_lines  = two_lines;
   assign meta.tlb_miss   = rd_miss_q;
   assign meta.prot_fault = rd_valid_q && !rd_hit_q && !rd_miss_q;

   // Second page is never translated
   assign page_end = {1'b0, rd_paddr_i[`DC_PAGE_OFS_W-1:0]}
                   + (`DC_PAGE_OFS_W+1)'(1 << rd_size_i);

   a_no_page_cross : assert property (@(posedge clk) disable iff (!arst_n_i)
      rd_valid_i && rd_hit_i |-> page_end <= (1 << `DC_PAGE_OFS_W))
      else $error("access_split: read at %h crosses a page", rd_paddr_i);

endmodule

`default_nettype wire

// ==== dtlb.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "dcache_cfg.svh"

module dtlb
   import dcache_tlb_pkg::*;
   import dcache_mem_pkg::*;
(
   input  wire vaddr_t        vaddr_i,
   input  wire logic          is_write_i,
   input  wire tlb_vpn_vec_t  vp_i,
   input  wire tlb_ppn_vec_t  pf_i,
   input  wire tlb_flag_vec_t v_i,
   input  wire tlb_flag_vec_t p_i,
   input  wire tlb_flag_vec_t rw_i,
   output paddr_t             paddr_o,
   output logic               hit_o,
   output logic               miss_o,
   output logic               prot_o
);

   vpn_t          vpn;
   tlb_flag_vec_t match;
   tlb_flag_vec_t present;
   ppn_t          frame;

   assign vpn = vaddr_i[`DC_VADDR_W-1:`DC_PAGE_OFS_W];

   // All entries compared in parallel
   always_comb begin
      frame = '0;
      for (int i = 0; i < `DC_TLB_ENTRIES; i++) begin
         match[i] = v_i[i] && (vp_i[i*`DC_VPN_W +: `DC_VPN_W] == vpn);
         if (match[i]) begin
            frame = frame | pf_i[i*`DC_VPN_W +: `DC_PPN_W];
         end
      end
   end

   assign present = match & p_i;
   assign miss_o  = ~|present;
   // Write to a page without RW
   assign prot_o  = is_write_i && |(present & ~rw_i);
   assign hit_o   = !miss_o && !prot_o;
   assign paddr_o = {frame, vaddr_i[`DC_PAGE_OFS_W-1:0]};

   always_comb begin
      assert ($isunknown(match) || $onehot0(match))
         else $error("dtlb: several valid entries match vpn %h", vpn);
   end

endmodule

`default_nettype wire

// ==== dcache_if.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "dcache_cfg.svh"

// Request strobes for one bank
interface bank_req_if
   import dcache_mem_pkg::*;
();
   logic   rd_valid;
   index_t rd_index;
   tag_t   rd_tag;
   logic   wr_valid;
   index_t wr_index;
   tag_t   wr_tag;
   line_t  wr_line;

   modport split (output rd_valid, rd_index, rd_tag,
                  output wr_valid, wr_index, wr_tag, wr_line);
   modport bank  (input rd_valid, rd_index, rd_tag,
                  input wr_valid, wr_index, wr_tag, wr_line);
endinterface

// What the aligner needs to know about a read in flight
interface rd_meta_if
   import dcache_mem_pkg::*;
();
   logic    valid;
   offset_t offset;
   opsize_t size;
   logic    first_odd;
   logic    two_lines;
   logic    tlb_miss;
   logic    prot_fault;

   modport split (output valid, offset, size, first_odd, two_lines, tlb_miss, prot_fault);
   modport align (input valid, offset, size, first_odd, two_lines, tlb_miss, prot_fault);
endinterface

`default_nettype wire

// ==== dcache_mem_pkg.sv ====
`default_nettype none
`include "dcache_cfg.svh"

package dcache_mem_pkg;

   localparam int OFFSET_W = $clog2(`DC_LINE_BYTES);
   localparam int INDEX_W  = $clog2(`DC_SETS_PER_BANK);
   // Bank select bit sits between offset and index
   localparam int TAG_W    = `DC_PADDR_W - INDEX_W - 1 - OFFSET_W;

   typedef logic [`DC_PADDR_W-1:0]      paddr_t;
   typedef logic [`DC_LINE_BYTES*8-1:0] line_t;
   typedef logic [`DC_WORD_BYTES*8-1:0] word_t;

   typedef logic [INDEX_W-1:0]  index_t;
   typedef logic [TAG_W-1:0]    tag_t;
   typedef logic [OFFSET_W-1:0] offset_t;

   // Codes 0..3 select 1, 2, 4 or 8 bytes
   typedef logic [1:0] opsize_t;

endpackage

`default_nettype wire

// ==== dcache_tlb_pkg.sv ====
`default_nettype none
`include "dcache_cfg.svh"

package dcache_tlb_pkg;

   typedef logic [`DC_VADDR_W-1:0] vaddr_t;
   typedef logic [`DC_VPN_W-1:0]   vpn_t;
   typedef logic [`DC_PPN_W-1:0]   ppn_t;

   // Entry i sits at bits i*20 +: 20 in both vectors
   typedef logic [`DC_TLB_ENTRIES*`DC_VPN_W-1:0] tlb_vpn_vec_t;
   // Only the low frame bits of each 20-bit slot are used
   typedef logic [`DC_TLB_ENTRIES*`DC_VPN_W-1:0] tlb_ppn_vec_t;

   typedef logic [`DC_TLB_ENTRIES-1:0] tlb_flag_vec_t;

endpackage

`default_nettype wire

// ==== dcache_cfg.svh ====
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// Address widths
`define DC_VADDR_W        32
`define DC_PADDR_W        15
`define DC_PAGE_OFS_W     12
`define DC_VPN_W          20
`define DC_PPN_W          3

`define DC_TLB_ENTRIES    8

// Bank geometry with line and read word sizes in bytes
`define DC_LINE_BYTES     16
`define DC_SETS_PER_BANK  8
`define DC_WORD_BYTES     8

`endif
